//--- src/cache_defines.svh
// Cache geometry macros: address, line, offset, index, tag and byte-enable widths.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address from the CPU and to memory.
`define CACHE_ADDR_W   32

// One cache line, moved whole on both ports.
`define CACHE_LINE_W   256

// Byte offset inside a line.
`define CACHE_OFFSET_W 5

// Set index, 8 sets.
`define CACHE_INDEX_W  3

// Whatever is left of the address is tag.
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// One enable bit per byte of a line.
`define CACHE_MBE_W    (`CACHE_LINE_W / 8)

`endif

//--- src/cache_pkg.sv
// Cache package: line, tag, index and byte-enable types, and the datapath mux selects.
package cache_pkg;

`include "cache_defines.svh"

    //////////////////////////////
    // Payload types
    //////////////////////////////

    typedef logic [`CACHE_LINE_W-1:0]  line_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_MBE_W-1:0]   mbe_t;

    //////////////////////////////
    // Mux selects
    //////////////////////////////

    typedef enum logic {
        dimux_cpu_wdata,               // CPU write data.
        dimux_pmem_rdata               // Line read from memory.
    } dimux_sel_t;

    typedef enum logic {
        domux_way0,
        domux_way1
    } domux_sel_t;

    typedef enum logic [1:0] {
        wemux_zeros,                   // No byte written.
        wemux_mbe,                     // CPU byte enables.
        wemux_ones                     // Whole line.
    } wemux_sel_t;

    typedef enum logic [1:0] {
        addrmux_cpu,                   // Line address of the request.
        addrmux_way0,                  // Victim address from the way 0 tag.
        addrmux_way1                   // Victim address from the way 1 tag.
    } addrmux_sel_t;

endpackage

//--- src/cache_ctrl_if.sv
// Control/datapath interface: set status to the FSM, selects and array loads back.
`timescale 1ns/1ps

interface cache_ctrl_if;

    // Status of the addressed set.
    logic       lru;                   // 1 means way 1 is the victim.
    logic [1:0] valid;
    logic [1:0] dirty;
    logic [1:0] cmp;                   // Stored tag equals address tag.

    // Mux selects.
    cache_pkg::dimux_sel_t   dimux_sel;
    cache_pkg::domux_sel_t   domux_sel;
    cache_pkg::wemux_sel_t   wemux_sel [2];
    cache_pkg::addrmux_sel_t addrmux_sel;

    // Array loads and the values they write.
    logic       lru_load;
    logic [1:0] valid_load;
    logic [1:0] dirty_load;
    logic [1:0] tag_load;
    logic       lru_val;
    logic [1:0] valid_val;
    logic [1:0] dirty_val;

    modport ctrl (
        input  lru, valid, dirty, cmp,
        output dimux_sel, domux_sel, wemux_sel, addrmux_sel,
        output lru_load, valid_load, dirty_load, tag_load,
        output lru_val, valid_val, dirty_val
    );

    modport dp (
        output lru, valid, dirty, cmp,
        input  dimux_sel, domux_sel, wemux_sel, addrmux_sel,
        input  lru_load, valid_load, dirty_load, tag_load,
        input  lru_val, valid_val, dirty_val
    );

endinterface

//--- src/cache_array.sv
// Per-set storage of one value of any type, async read and clocked write.
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_array #(
    parameter type T = logic
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_i,
    input  cache_pkg::index_t index_i,
    input  T                  data_i,
    output T                  data_o
);

    localparam int num_sets = 1 << `CACHE_INDEX_W;

    T mem [num_sets];

    // All sets start empty, which clears valid, dirty and LRU.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < num_sets; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (load_i)
        begin
            mem[index_i] <= data_i;    // Write the addressed set.
        end
    end

    assign data_o = mem[index_i];      // Combinational read.

endmodule

//--- src/cache_datapath.sv
// Cache datapath: way arrays, tag compare, data and address muxes, byte merge.
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_datapath (
    input  logic                     clk,
    input  logic                     rst,
    cache_ctrl_if.dp                 ctrl,
    input  logic [`CACHE_ADDR_W-1:0] mem_address_i,
    input  cache_pkg::line_t         mem_wdata_i,
    input  cache_pkg::mbe_t          mem_byte_enable_i,
    output cache_pkg::line_t         mem_rdata_o,
    input  cache_pkg::line_t         pmem_rdata_i,
    output cache_pkg::line_t         pmem_wdata_o,
    output logic [`CACHE_ADDR_W-1:0] pmem_address_o
);

    cache_pkg::tag_t   addr_tag;
    cache_pkg::index_t addr_index;
    cache_pkg::line_t  din;
    cache_pkg::line_t  dout_sel;
    cache_pkg::line_t  dout [2];
    cache_pkg::line_t  merged [2];
    cache_pkg::mbe_t   wmask [2];
    cache_pkg::tag_t   tag_q [2];
    logic [1:0]        data_load;
    logic [1:0]        valid_q;
    logic [1:0]        dirty_q;
    logic [1:0]        cmp_w;

    assign addr_tag   = mem_address_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign addr_index = mem_address_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // Data-in source.
    assign din = (ctrl.dimux_sel == cache_pkg::dimux_pmem_rdata) ? pmem_rdata_i : mem_wdata_i;

    //////////////////////////////
    // Write masks and byte merge
    //////////////////////////////

    always_comb
    begin
        for (int w = 0; w < 2; w++)
        begin
            case (ctrl.wemux_sel[w])
                cache_pkg::wemux_mbe:  wmask[w] = mem_byte_enable_i;
                cache_pkg::wemux_ones: wmask[w] = '1;
                default:               wmask[w] = '0;
            endcase
            // Unmasked bytes keep what the way holds.
            for (int b = 0; b < `CACHE_MBE_W; b++)
            begin
                merged[w][8*b +: 8] = wmask[w][b] ? din[8*b +: 8] : dout[w][8*b +: 8];
            end
        end
    end

    //////////////////////////////
    // Ways
    //////////////////////////////

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        assign data_load[w] = |wmask[w];
        assign cmp_w[w]     = (tag_q[w] == addr_tag);

        cache_array #(.T(cache_pkg::line_t)) u_data (
            .clk     (clk),
            .rst     (rst),
            .load_i  (data_load[w]),
            .index_i (addr_index),
            .data_i  (merged[w]),
            .data_o  (dout[w])
        );

        cache_array #(.T(cache_pkg::tag_t)) u_tag (
            .clk     (clk),
            .rst     (rst),
            .load_i  (ctrl.tag_load[w]),
            .index_i (addr_index),
            .data_i  (addr_tag),
            .data_o  (tag_q[w])
        );

        cache_array #(.T(logic)) u_valid (
            .clk     (clk),
            .rst     (rst),
            .load_i  (ctrl.valid_load[w]),
            .index_i (addr_index),
            .data_i  (ctrl.valid_val[w]),
            .data_o  (valid_q[w])
        );

        cache_array #(.T(logic)) u_dirty (
            .clk     (clk),
            .rst     (rst),
            .load_i  (ctrl.dirty_load[w]),
            .index_i (addr_index),
            .data_i  (ctrl.dirty_val[w]),
            .data_o  (dirty_q[w])
        );
    end

    // One LRU bit per set, shared by both ways.
    cache_array #(.T(logic)) u_lru (
        .clk     (clk),
        .rst     (rst),
        .load_i  (ctrl.lru_load),
        .index_i (addr_index),
        .data_i  (ctrl.lru_val),
        .data_o  (ctrl.lru)
    );

    assign ctrl.valid = valid_q;
    assign ctrl.dirty = dirty_q;
    assign ctrl.cmp   = cmp_w;

    // The selected way feeds both the CPU and the write-back.
    assign dout_sel     = (ctrl.domux_sel == cache_pkg::domux_way1) ? dout[1] : dout[0];
    assign mem_rdata_o  = dout_sel;
    assign pmem_wdata_o = dout_sel;

    // Line-aligned memory address, victim tag during write-back.
    always_comb
    begin
        case (ctrl.addrmux_sel)
            cache_pkg::addrmux_way0:
                pmem_address_o = {tag_q[0], addr_index, {`CACHE_OFFSET_W{1'b0}}};
            cache_pkg::addrmux_way1:
                pmem_address_o = {tag_q[1], addr_index, {`CACHE_OFFSET_W{1'b0}}};
            default:
                pmem_address_o = {addr_tag, addr_index, {`CACHE_OFFSET_W{1'b0}}};
        endcase
    end

endmodule

//--- src/cache_control.sv
// Cache control FSM: hit check, write-back of a dirty victim, and line refill.
`timescale 1ns/1ps

module cache_control (
    input  logic       clk,
    input  logic       rst,
    cache_ctrl_if.ctrl ctrl,
    input  logic       mem_read_i,
    input  logic       mem_write_i,
    output logic       mem_resp_o,
    input  logic       pmem_resp_i,
    output logic       pmem_read_o,
    output logic       pmem_write_o
);

    typedef enum logic [1:0] {
        st_hit_check,
        st_write_back,
        st_read_back
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [1:0] hit;
    logic       hit_way;
    logic       request;

    assign request = mem_read_i | mem_write_i;
    assign hit     = ctrl.valid & ctrl.cmp;  // A way hits only when valid.
    assign hit_way = hit[1];

    //////////////////////////////
    // Outputs
    //////////////////////////////

    always_comb
    begin
        // Idle values, nothing written.
        ctrl.dimux_sel    = cache_pkg::dimux_cpu_wdata;
        ctrl.domux_sel    = cache_pkg::domux_way0;
        ctrl.wemux_sel[0] = cache_pkg::wemux_zeros;
        ctrl.wemux_sel[1] = cache_pkg::wemux_zeros;
        ctrl.addrmux_sel  = cache_pkg::addrmux_cpu;
        ctrl.lru_load     = 1'b0;
        ctrl.lru_val      = 1'b0;
        ctrl.valid_load   = 2'b00;
        ctrl.valid_val    = 2'b00;
        ctrl.dirty_load   = 2'b00;
        ctrl.dirty_val    = 2'b00;
        ctrl.tag_load     = 2'b00;
        mem_resp_o        = 1'b0;
        pmem_read_o       = 1'b0;
        pmem_write_o      = 1'b0;

        case (state)
            st_hit_check:
            begin
                if (request && (hit != 2'b00))
                begin
                    mem_resp_o     = 1'b1;
                    ctrl.lru_load  = 1'b1;
                    ctrl.lru_val   = hit[0];           // Victim is the other way.
                    ctrl.domux_sel = cache_pkg::domux_sel_t'(hit_way);
                    if (mem_write_i)
                    begin
                        ctrl.dimux_sel          = cache_pkg::dimux_cpu_wdata;
                        ctrl.wemux_sel[hit_way] = cache_pkg::wemux_mbe;
                        ctrl.dirty_load[hit_way] = 1'b1;
                        ctrl.dirty_val[hit_way]  = 1'b1;
                    end
                end
            end
            st_write_back:
            begin
                pmem_write_o   = 1'b1;
                ctrl.domux_sel = cache_pkg::domux_sel_t'(ctrl.lru);
                ctrl.addrmux_sel = ctrl.lru ? cache_pkg::addrmux_way1 : cache_pkg::addrmux_way0;
            end
            st_read_back:
            begin
                pmem_read_o    = 1'b1;
                ctrl.dimux_sel = cache_pkg::dimux_pmem_rdata;
                // Fill the victim in the cycle the line arrives.
                if (pmem_resp_i)
                begin
                    ctrl.wemux_sel[ctrl.lru]  = cache_pkg::wemux_ones;
                    ctrl.tag_load[ctrl.lru]   = 1'b1;
                    ctrl.valid_load[ctrl.lru] = 1'b1;
                    ctrl.valid_val[ctrl.lru]  = 1'b1;
                    ctrl.dirty_load[ctrl.lru] = 1'b1;
                    ctrl.dirty_val[ctrl.lru]  = 1'b0;
                end
            end
            default:
            begin
            end
        endcase
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            st_hit_check:
            begin
                if (request && (hit == 2'b00))
                begin
                    // A dirty victim goes to memory before the refill.
                    if (ctrl.valid[ctrl.lru] && ctrl.dirty[ctrl.lru])
                        next_state = st_write_back;
                    else
                        next_state = st_read_back;
                end
            end
            st_write_back:
            begin
                if (pmem_resp_i)
                    next_state = st_read_back;
            end
            st_read_back:
            begin
                if (pmem_resp_i)
                    next_state = st_hit_check;     // Request then hits.
            end
            default:
            begin
                next_state = st_hit_check;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_hit_check;
        else
            state <= next_state;
    end

endmodule

//--- src/cache.sv
// Cache top level: control FSM and datapath joined by the control interface.
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache (
    input  logic                     clk,
    input  logic                     rst,
    // CPU side.
    input  logic [`CACHE_ADDR_W-1:0] mem_address_i,
    input  logic                     mem_read_i,
    input  logic                     mem_write_i,
    input  cache_pkg::line_t         mem_wdata_i,
    input  cache_pkg::mbe_t          mem_byte_enable_i,
    output cache_pkg::line_t         mem_rdata_o,
    output logic                     mem_resp_o,
    // Memory side.
    input  cache_pkg::line_t         pmem_rdata_i,
    input  logic                     pmem_resp_i,
    output logic [`CACHE_ADDR_W-1:0] pmem_address_o,
    output cache_pkg::line_t         pmem_wdata_o,
    output logic                     pmem_read_o,
    output logic                     pmem_write_o
);

    cache_ctrl_if u_ctrl_if ();

    cache_control u_control (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (u_ctrl_if.ctrl),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_resp_o   (mem_resp_o),
        .pmem_resp_i  (pmem_resp_i),
        .pmem_read_o  (pmem_read_o),
        .pmem_write_o (pmem_write_o)
    );

    cache_datapath u_datapath (
        .clk               (clk),
        .rst               (rst),
        .ctrl              (u_ctrl_if.dp),
        .mem_address_i     (mem_address_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_rdata_o       (mem_rdata_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_address_o    (pmem_address_o)
    );

endmodule

//--- bench/cache_tb.sv
// Cache testbench: clock, reset, memory model with random latency, random CPU requests, checks.
`timescale 1ns/1ps

module cache_tb;

    logic             clk;
    logic             rst;
    logic [31:0]      mem_address_i;
    logic             mem_read_i;
    logic             mem_write_i;
    cache_pkg::line_t mem_wdata_i;
    cache_pkg::mbe_t  mem_byte_enable_i;
    cache_pkg::line_t mem_rdata_o;
    logic             mem_resp_o;
    cache_pkg::line_t pmem_rdata_i;
    logic             pmem_resp_i;
    logic [31:0]      pmem_address_o;
    cache_pkg::line_t pmem_wdata_o;
    logic             pmem_read_o;
    logic             pmem_write_o;

    integer           seed = 32'hd9d2_acdd;
    cache_pkg::line_t pmem_model [logic [31:0]];  // Backing memory, lines filled on first touch.
    cache_pkg::line_t ref_mem [logic [31:0]];     // Architectural image seen by the CPU.
    cache_pkg::tag_t  sh_tag [8][2];
    logic             sh_valid [8][2];
    logic             sh_dirty [8][2];
    logic             sh_lru [8];                 // 1 means way 1 is the victim.
    int               rd_count;
    int               wr_count;
    logic [31:0]      last_rd_addr;
    logic [31:0]      last_wr_addr;
    cache_pkg::line_t last_wr_data;

    cache u_cache (
        .clk               (clk),
        .rst               (rst),
        .mem_address_i     (mem_address_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_resp_o        (mem_resp_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_resp_i       (pmem_resp_i),
        .pmem_address_o    (pmem_address_o),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_read_o       (pmem_read_o),
        .pmem_write_o      (pmem_write_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check.");
    endtask

    // Each word carries the line address and its position.
    function automatic cache_pkg::line_t fill_line(input logic [31:0] line_addr);
        cache_pkg::line_t line;
        for (int i = 0; i < 8; i++)
        begin
            line[32*i +: 32] = {line_addr[31:5], i[4:0]} ^ 32'hc3a5_96e1;
        end
        return line;
    endfunction

    function automatic cache_pkg::line_t ref_line(input logic [31:0] line_addr);
        if (!ref_mem.exists(line_addr))
            ref_mem[line_addr] = fill_line(line_addr);
        return ref_mem[line_addr];
    endfunction

    function automatic cache_pkg::line_t pmem_line(input logic [31:0] line_addr);
        if (!pmem_model.exists(line_addr))
            pmem_model[line_addr] = fill_line(line_addr);
        return pmem_model[line_addr];
    endfunction

    // Three tags over two sets, so the sets overflow.
    function automatic cache_pkg::tag_t pick_tag(input int n);
        case (n)
            0:       return 24'h00_1234;
            1:       return 24'h0a_bc00;
            default: return 24'hf0_0f5a;
        endcase
    endfunction

    //////////////////////////////
    // Physical memory model
    //////////////////////////////

    initial
    begin
        logic [31:0]      addr;
        cache_pkg::line_t wdata;
        logic             is_wr;
        int               delay;
        pmem_resp_i  <= 1'b0;
        pmem_rdata_i <= '0;
        forever
        begin
            @(negedge clk);
            if (pmem_read_o || pmem_write_o)
            begin
                addr  = pmem_address_o;
                wdata = pmem_wdata_o;
                is_wr = pmem_write_o;
                assert (addr[4:0] == 5'd0 && !(pmem_read_o && pmem_write_o))
                else stop_run($sformatf("Error at %0t ns: bad memory request at %h", $time, addr));
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                if (is_wr)
                begin
                    pmem_model[addr] = wdata;
                    wr_count++;
                    last_wr_addr = addr;
                    last_wr_data = wdata;
                end
                else
                begin
                    pmem_rdata_i <= pmem_line(addr);
                    rd_count++;
                    last_rd_addr = addr;
                end
                pmem_resp_i <= 1'b1;                  // One-cycle response.
                @(posedge clk);
                pmem_resp_i <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // CPU driver and reference model
    //////////////////////////////

    task automatic do_request(input logic [31:0] addr, input logic is_write,
                              input cache_pkg::line_t wdata, input cache_pkg::mbe_t mbe);
        logic [2:0]       set;
        cache_pkg::tag_t  tag;
        logic [31:0]      line_addr;
        logic [31:0]      victim_addr;
        logic             hit0;
        logic             hit1;
        logic             exp_hit;
        logic             exp_wb;
        logic             way;
        cache_pkg::line_t expected;
        cache_pkg::line_t victim_data;
        int               cycles;
        set       = addr[7:5];
        tag       = addr[31:8];
        line_addr = {tag, set, 5'b0};
        @(posedge clk);
        rd_count = 0;
        wr_count = 0;
        mem_address_i     <= addr;
        mem_read_i        <= !is_write;
        mem_write_i       <= is_write;
        mem_wdata_i       <= wdata;
        mem_byte_enable_i <= mbe;
        hit0    = sh_valid[set][0] && (sh_tag[set][0] == tag);
        hit1    = sh_valid[set][1] && (sh_tag[set][1] == tag);
        exp_hit = hit0 || hit1;
        way     = exp_hit ? hit1 : sh_lru[set];
        exp_wb  = !exp_hit && sh_valid[set][way] && sh_dirty[set][way];
        victim_addr = {sh_tag[set][way], set, 5'b0};
        victim_data = ref_line(victim_addr);
        expected    = ref_line(line_addr);
        @(negedge clk);
        if (exp_hit)
        begin
            assert (mem_resp_o && !pmem_read_o && !pmem_write_o)
            else stop_run($sformatf("Error at %0t ns: hit on %h not answered at once", $time, addr));
        end
        else
        begin
            assert (!mem_resp_o)
            else stop_run($sformatf("Error at %0t ns: miss on %h answered at once", $time, addr));
        end
        cycles = 0;
        while (!mem_resp_o)
        begin
            assert (cycles < 200)
            else stop_run("Timeout: the cache gave no response within 200 cycles.");
            @(negedge clk);
            cycles++;
        end
        if (!is_write)
        begin
            assert (mem_rdata_o == expected)
            else stop_run($sformatf("Error at %0t ns: read of %h returned %h, expected %h",
                                    $time, addr, mem_rdata_o, expected));
        end
        assert (rd_count == (exp_hit ? 0 : 1) && wr_count == (exp_wb ? 1 : 0))
        else stop_run($sformatf("Error at %0t ns: %0d reads and %0d writes to memory for %h",
                                $time, rd_count, wr_count, addr));
        if (!exp_hit)
        begin
            assert (last_rd_addr == line_addr)
            else stop_run($sformatf("Error at %0t ns: refill from %h, expected %h",
                                    $time, last_rd_addr, line_addr));
        end
        if (exp_wb)
        begin
            assert (last_wr_addr == victim_addr && last_wr_data == victim_data)
            else stop_run($sformatf("Error at %0t ns: write-back to %h, expected %h",
                                    $time, last_wr_addr, victim_addr));
        end
        // Shadow update, refill first, then the hit that answers.
        if (!exp_hit)
        begin
            sh_tag[set][way]   = tag;
            sh_valid[set][way] = 1'b1;
            sh_dirty[set][way] = 1'b0;
        end
        sh_lru[set] = (way == 1'b0);
        if (is_write)
        begin
            sh_dirty[set][way] = 1'b1;
            for (int b = 0; b < 32; b++)
            begin
                if (mbe[b])
                    expected[8*b +: 8] = wdata[8*b +: 8];
            end
            ref_mem[line_addr] = expected;
        end
        @(posedge clk);
        mem_read_i  <= 1'b0;                          // Request dropped after the response.
        mem_write_i <= 1'b0;
    endtask

    initial
    begin
        logic [31:0]      rnd;
        cache_pkg::line_t data;
        cache_pkg::mbe_t  mbe;
        int               tag_n;
        for (int s = 0; s < 8; s++)
        begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                sh_tag[s][w]   = '0;
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
            end
        end
        rst               <= 1'b1;
        mem_address_i     <= '0;
        mem_read_i        <= 1'b0;
        mem_write_i       <= 1'b0;
        mem_wdata_i       <= '0;
        mem_byte_enable_i <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // Idle after reset.
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            assert (!mem_resp_o && !pmem_read_o && !pmem_write_o)
            else stop_run($sformatf("Error at %0t ns: activity with no request", $time));
        end
        for (int n = 0; n < 400; n++)
        begin
            rnd   = $random(seed);
            tag_n = $unsigned($random(seed)) % 3;
            mbe   = $random(seed);
            for (int i = 0; i < 8; i++)
            begin
                data[32*i +: 32] = $random(seed);
            end
            do_request({pick_tag(tag_n), (rnd[1] ? 3'd6 : 3'd1), rnd[8:4]}, rnd[0], data, mbe);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- cache.f
+incdir+src
src/cache_pkg.sv
src/cache_ctrl_if.sv
src/cache_array.sv
src/cache_datapath.sv
src/cache_control.sv
src/cache.sv
bench/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cache_tb
FILELIST  ?= cache.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits non-zero when the testbench stops on a failed check.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
